/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = basic_soc_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

# The run passes only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* build.f */
common/bus_pkg.sv
common/soc_map_pkg.sv
bus/axil_decoder.sv
verilog/axil_sram.sv
verilog/axil_gpio.sv
verilog/basic_soc.sv
test/basic_soc_tb.sv

/* bus/axil_decoder.sv */
`timescale 1ns/1ps

module axil_decoder
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata_in,
    input  logic [STRB_W-1:0] wstrb_in,
    input  logic              wvalid,
    output logic              wready,
    output axil_resp_e        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output axil_resp_e        rresp,
    output logic              rvalid,
    input  logic              rready,

    output logic              sel_sram,
    output logic              sel_gpio,
    output logic              wr_en,
    output logic              rd_en,
    output logic [ADDR_W-1:0] reg_addr,
    output logic [DATA_W-1:0] wdata,
    output logic [STRB_W-1:0] wstrb,
    input  logic [DATA_W-1:0] sram_rdata,
    input  logic [DATA_W-1:0] gpio_rdata
);

    dec_state_e state;
    dev_sel_e dev_q;
    dev_sel_e req_dev;
    logic is_write;
    logic settle;
    logic wr_accept;
    logic rd_accept;
    logic [ADDR_W-1:0] req_addr;
    axil_resp_e resp_code;

    // A write needs both address and data present; it beats a pending read
    assign wr_accept = (state == IDLE) && awvalid && wvalid;
    assign rd_accept = (state == IDLE) && arvalid && !(awvalid && wvalid);
    assign awready = wr_accept;
    assign wready = wr_accept;
    assign arready = rd_accept;

    assign req_addr = wr_accept ? awaddr : araddr;
    assign req_dev = addr_dev(req_addr);

    assign sel_sram = (dev_q == DEV_SRAM);
    assign sel_gpio = (dev_q == DEV_GPIO);
    assign resp_code = (dev_q == DEV_NONE) ? RESP_DECERR : RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            dev_q <= DEV_NONE;
            is_write <= 1'b0;
            settle <= 1'b0;
            wr_en <= 1'b0;
            rd_en <= 1'b0;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            rd_en <= 1'b0;
            case (state)
                IDLE: begin
                    if (wr_accept || rd_accept) begin
                        state <= ACCESS;
                        dev_q <= req_dev;
                        is_write <= wr_accept;
                        settle <= 1'b0;
                        // Unmapped addresses never reach a device
                        wr_en <= wr_accept && (req_dev != DEV_NONE);
                        rd_en <= rd_accept && (req_dev != DEV_NONE);
                    end
                end
                ACCESS: begin
                    // Second cycle is where the device read data becomes valid
                    if (!settle) begin
                        settle <= 1'b1;
                    end else begin
                        state <= RESPOND;
                        bvalid <= is_write;
                        rvalid <= !is_write;
                    end
                end
                RESPOND: begin
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        state <= IDLE;
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept || rd_accept) begin
            reg_addr <= dev_offset(req_addr, req_dev);
            wdata <= wdata_in;
            wstrb <= wstrb_in;
        end
        if ((state == ACCESS) && settle) begin
            bresp <= resp_code;
            rresp <= resp_code;
            case (dev_q)
                DEV_SRAM: rdata <= sram_rdata;
                DEV_GPIO: rdata <= gpio_rdata;
                default:  rdata <= '0;
            endcase
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && rd_en))
        else $error("wr_en and rd_en high in the same cycle");

    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("read response dropped or changed before rready");

endmodule

/* common/bus_pkg.sv */
package bus_pkg;

    // AXI4-Lite bus geometry
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axil_resp_e;

    // One transaction at a time: take it, strobe the device, then hold the response
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RESPOND = 2'd2
    } dec_state_e;

endpackage

/* common/soc_map_pkg.sv */
package soc_map_pkg;

    import bus_pkg::*;

    localparam logic [ADDR_W-1:0] SRAM_BASE = 16'h0000;
    localparam int SRAM_WORDS = 256;
    localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
    localparam logic [ADDR_W-1:0] SRAM_SPAN = ADDR_W'(SRAM_WORDS * 4);

    localparam logic [ADDR_W-1:0] GPIO_BASE = 16'h1000;
    localparam logic [ADDR_W-1:0] GPIO_SPAN = 16'h0008;
    localparam logic [ADDR_W-1:0] GPIO_OUT_OFS = 16'h0000;
    localparam logic [ADDR_W-1:0] GPIO_IN_OFS = 16'h0004;
    localparam int GPIO_IN_W = 8;

    typedef enum logic [1:0] {
        DEV_SRAM = 2'd0,
        DEV_GPIO = 2'd1,
        DEV_NONE = 2'd2
    } dev_sel_e;

    function automatic dev_sel_e addr_dev(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] sram_ofs;
        logic [ADDR_W-1:0] gpio_ofs;
        sram_ofs = addr - SRAM_BASE;
        gpio_ofs = addr - GPIO_BASE;
        if (sram_ofs < SRAM_SPAN) begin
            return DEV_SRAM;
        end
        if (gpio_ofs < GPIO_SPAN) begin
            return DEV_GPIO;
        end
        return DEV_NONE;
    endfunction

    // Devices see addresses relative to their own base
    function automatic logic [ADDR_W-1:0] dev_offset(input logic [ADDR_W-1:0] addr,
                                                     input dev_sel_e dev);
        case (dev)
            DEV_SRAM: return addr - SRAM_BASE;
            DEV_GPIO: return addr - GPIO_BASE;
            default:  return '0;
        endcase
    endfunction

endpackage

/* test/basic_soc_tb.sv */
`timescale 1ns/1ps

module basic_soc_tb
    import bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RESET_CYCLES = 5;
    localparam int GPIO_OUTPUTS = 4;
    localparam int NUM_STEPS = 21;
    localparam int WAIT_LIMIT = 16;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PIN} op_e;

    typedef struct packed {
        op_e op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        axil_resp_e resp;
    } step_t;

    // Write data comes from the LCG and the data column only sets the input pins
    localparam step_t STEPS [NUM_STEPS] = '{
        '{OP_WR,  16'h0000, 32'h0, 4'hF, RESP_OKAY},
        '{OP_WR,  16'h0004, 32'h0, 4'hF, RESP_OKAY},
        '{OP_WR,  16'h03FC, 32'h0, 4'hF, RESP_OKAY},
        '{OP_RD,  16'h0000, 32'h0, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h0004, 32'h0, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h03FC, 32'h0, 4'h0, RESP_OKAY},
        '{OP_WR,  16'h0004, 32'h0, 4'h5, RESP_OKAY},
        '{OP_WR,  16'h03FC, 32'h0, 4'h8, RESP_OKAY},
        '{OP_RD,  16'h0004, 32'h0, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h03FC, 32'h0, 4'h0, RESP_OKAY},
        '{OP_WR,  16'h1000, 32'h0, 4'hF, RESP_OKAY},
        '{OP_RD,  16'h1000, 32'h0, 4'h0, RESP_OKAY},
        '{OP_PIN, 16'h0000, 32'hA5, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h1004, 32'h0, 4'h0, RESP_OKAY},
        '{OP_WR,  16'h2004, 32'h0, 4'hF, RESP_DECERR},
        '{OP_RD,  16'h2004, 32'h0, 4'h0, RESP_DECERR},
        '{OP_RD,  16'h0004, 32'h0, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h1000, 32'h0, 4'h0, RESP_OKAY},
        '{OP_RD,  16'h0400, 32'h0, 4'h0, RESP_DECERR},
        '{OP_WR,  16'h1000, 32'h0, 4'hE, RESP_OKAY},
        '{OP_RD,  16'h1000, 32'h0, 4'h0, RESP_OKAY}
    };

    logic clk = 1'b0;
    logic rst_n;
    logic [ADDR_W-1:0] awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [DATA_W-1:0] wdata, rdata;
    logic [STRB_W-1:0] wstrb;
    axil_resp_e bresp, rresp;
    logic [GPIO_IN_W-1:0] gpio_inputs;
    logic [GPIO_OUTPUTS-1:0] gpio_outputs;

    logic [DATA_W-1:0] sram_model [SRAM_WORDS];
    logic [GPIO_OUTPUTS-1:0] out_model = '0;
    logic [GPIO_IN_W-1:0] pin_model = '0;
    logic [31:0] rng_state = 32'd81;
    int checks = 0;
    int mismatches = 0;
    int failures = 0;

    basic_soc #(.GPIO_OUTPUTS(GPIO_OUTPUTS)) dut_i (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic dev_sel_e map_region(input logic [ADDR_W-1:0] addr);
        if (int'(addr) < SRAM_WORDS * 4) return DEV_SRAM;
        if (addr >= GPIO_BASE && addr < GPIO_BASE + 16'h8) return DEV_GPIO;
        return DEV_NONE;
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                               input logic [STRB_W-1:0] strb);
        if (map_region(addr) == DEV_SRAM) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) sram_model[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
            end
        end else if (addr == GPIO_BASE + GPIO_OUT_OFS && strb[0]) begin
            out_model = data[GPIO_OUTPUTS-1:0];
        end
    endtask

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        if (map_region(addr) == DEV_SRAM) return sram_model[addr[9:2]];
        if (addr == GPIO_BASE + GPIO_OUT_OFS) return DATA_W'(out_model);
        if (addr == GPIO_BASE + GPIO_IN_OFS) return DATA_W'(pin_model);
        return '0;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic bus_access(input step_t s);
        logic [DATA_W-1:0] wr_data;
        logic [DATA_W-1:0] held_data;
        logic [1:0] held_resp;
        logic is_wr;
        logic hs;
        logic resp_valid;
        int cycles;
        int delay;
        is_wr = (s.op == OP_WR);
        wr_data = lcg_next();
        @(negedge clk);
        awaddr = s.addr;
        araddr = s.addr;
        wdata = wr_data;
        wstrb = s.strb;
        awvalid = is_wr;
        wvalid = is_wr;
        arvalid = !is_wr;
        hs = 1'b0;
        cycles = 0;
        while (!hs && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            hs = is_wr ? (awready && wready) : arready;
            cycles++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        // Count edges from the handshake until the response shows up
        cycles = 0;
        resp_valid = is_wr ? bvalid : rvalid;
        while (hs && !resp_valid && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
            resp_valid = is_wr ? bvalid : rvalid;
        end
        if (!hs || !resp_valid) begin
            failures++;
            $display("Timeout at %0t ns: access to %h got no handshake or no response",
                     $time, s.addr);
            return;
        end
        check_value("handshake to valid cycles", DATA_W'(cycles), 2);
        if (is_wr) begin
            model_write(s.addr, wr_data, s.strb);
            check_value("bresp", DATA_W'(bresp), DATA_W'(s.resp));
        end else begin
            check_value("rdata", rdata, model_read(s.addr));
            check_value("rresp", DATA_W'(rresp), DATA_W'(s.resp));
        end
        held_data = rdata;
        held_resp = is_wr ? bresp : rresp;
        delay = int'(lcg_next() >> 16) % 4;
        // Offer the other kind of request while the response waits
        repeat (delay) begin
            awvalid = !is_wr;
            wvalid = !is_wr;
            arvalid = is_wr;
            @(negedge clk);
            check_value(is_wr ? "bvalid" : "rvalid", DATA_W'(is_wr ? bvalid : rvalid), 1);
            check_value(is_wr ? "bresp" : "rresp", DATA_W'(is_wr ? bresp : rresp),
                        DATA_W'(held_resp));
            check_value("rdata", rdata, held_data);
            check_value("awready", DATA_W'(awready), 0);
            check_value("arready", DATA_W'(arready), 0);
        end
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        bready = is_wr;
        rready = !is_wr;
        @(posedge clk);
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
        check_value(is_wr ? "bvalid" : "rvalid", DATA_W'(is_wr ? bvalid : rvalid), 0);
    endtask

    initial begin
        rst_n = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        gpio_inputs = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_value("ready and valid after reset",
                    DATA_W'({awready, wready, arready, bvalid, rvalid}), 0);
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (STEPS[i].op == OP_PIN) begin
                @(negedge clk);
                gpio_inputs = STEPS[i].data[GPIO_IN_W-1:0];
                pin_model = STEPS[i].data[GPIO_IN_W-1:0];
                // Two synchronizer stages plus margin before the next read
                repeat (3) @(negedge clk);
            end else begin
                bus_access(STEPS[i]);
            end
            check_value("gpio_outputs", DATA_W'(gpio_outputs), DATA_W'(out_model));
        end
        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_STEPS * 40) @(posedge clk);
        $display("Watchdog expired at %0t ns before the table was done", $time);
        $display("Checks: %0d, mismatches: %0d, other failures: %0d",
                 checks, mismatches, failures + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* verilog/axil_gpio.sv */
`timescale 1ns/1ps

module axil_gpio
    import bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int NUM_OUTPUTS = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sel,
    input  logic                   wr_en,
    input  logic                   rd_en,
    input  logic [ADDR_W-1:0]      addr,
    input  logic [DATA_W-1:0]      wdata,
    input  logic [STRB_W-1:0]      wstrb,
    input  logic [GPIO_IN_W-1:0]   gpio_inputs,
    output logic [DATA_W-1:0]      rdata,
    output logic [NUM_OUTPUTS-1:0] gpio_outputs
);

    logic [NUM_OUTPUTS-1:0] out_q;
    logic [GPIO_IN_W-1:0] sync_meta;
    logic [GPIO_IN_W-1:0] sync_in;

    assign gpio_outputs = out_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
            sync_meta <= '0;
            sync_in <= '0;
        end else begin
            // Pins are asynchronous to clk
            sync_meta <= gpio_inputs;
            sync_in <= sync_meta;
            if (sel && wr_en && (addr == GPIO_OUT_OFS)) begin
                for (int i = 0; i < NUM_OUTPUTS; i++) begin
                    if (wstrb[i / 8]) begin
                        out_q[i] <= wdata[i];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel && rd_en) begin
            case (addr)
                GPIO_OUT_OFS: rdata <= DATA_W'(out_q);
                GPIO_IN_OFS:  rdata <= DATA_W'(sync_in);
                default:      rdata <= '0;
            endcase
        end
    end

endmodule

/* verilog/axil_sram.sv */
`timescale 1ns/1ps

module axil_sram
    import bus_pkg::*;
    import soc_map_pkg::*;
(
    input  logic              clk,
    input  logic              sel,
    input  logic              wr_en,
    input  logic              rd_en,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic [STRB_W-1:0] wstrb,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [SRAM_IDX_W-1:0] word_idx;

    // Byte address in, word index out
    assign word_idx = addr[SRAM_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (sel && wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (wstrb[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, data follows rd_en by one cycle
    always_ff @(posedge clk) begin
        if (sel && rd_en) begin
            rdata <= mem[word_idx];
        end
    end

    // The decoder must only select the SRAM for offsets inside the array
    a_idx_range: assert property (@(posedge clk)
        sel && (wr_en || rd_en) |-> addr[ADDR_W-1:2] < SRAM_WORDS)
        else $error("SRAM access beyond %0d words at offset %h", SRAM_WORDS, addr);

endmodule

/* verilog/basic_soc.sv */
`timescale 1ns/1ps

module basic_soc
    import bus_pkg::*;
    import soc_map_pkg::*;
#(
    parameter int GPIO_OUTPUTS = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic [ADDR_W-1:0]       awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [DATA_W-1:0]       wdata,
    input  logic [STRB_W-1:0]       wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output axil_resp_e              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [ADDR_W-1:0]       araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [DATA_W-1:0]       rdata,
    output axil_resp_e              rresp,
    output logic                    rvalid,
    input  logic                    rready,

    input  logic [GPIO_IN_W-1:0]    gpio_inputs,
    output logic [GPIO_OUTPUTS-1:0] gpio_outputs
);

    logic sel_sram;
    logic sel_gpio;
    logic dev_wr_en;
    logic dev_rd_en;
    logic [ADDR_W-1:0] reg_addr;
    logic [DATA_W-1:0] dev_wdata;
    logic [STRB_W-1:0] dev_wstrb;
    logic [DATA_W-1:0] sram_rdata;
    logic [DATA_W-1:0] gpio_rdata;

    axil_decoder decoder_i (
        .clk,
        .rst_n,
        .awaddr,
        .awvalid,
        .awready,
        .wdata_in(wdata),
        .wstrb_in(wstrb),
        .wvalid,
        .wready,
        .bresp,
        .bvalid,
        .bready,
        .araddr,
        .arvalid,
        .arready,
        .rdata,
        .rresp,
        .rvalid,
        .rready,
        .sel_sram,
        .sel_gpio,
        .wr_en(dev_wr_en),
        .rd_en(dev_rd_en),
        .reg_addr,
        .wdata(dev_wdata),
        .wstrb(dev_wstrb),
        .sram_rdata,
        .gpio_rdata
    );

    axil_sram sram_i (
        .clk,
        .sel(sel_sram),
        .wr_en(dev_wr_en),
        .rd_en(dev_rd_en),
        .addr(reg_addr),
        .wdata(dev_wdata),
        .wstrb(dev_wstrb),
        .rdata(sram_rdata)
    );

    axil_gpio #(
        .NUM_OUTPUTS(GPIO_OUTPUTS)
    ) gpio_i (
        .clk,
        .rst_n,
        .sel(sel_gpio),
        .wr_en(dev_wr_en),
        .rd_en(dev_rd_en),
        .addr(reg_addr),
        .wdata(dev_wdata),
        .wstrb(dev_wstrb),
        .gpio_inputs,
        .rdata(gpio_rdata),
        .gpio_outputs
    );

endmodule
